/* verilog/mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// data path
`define MEM_XLEN        64
`define MEM_LINE_W      128

// cache geometry
`define MEM_LINES       16
`define MEM_OFS_BITS    4
`define MEM_IDX_BITS    4

// clint map, addr[31:24] picks the block
`define CLINT_HI_BYTE   8'h02
`define CLINT_MTIME_OFS 16'hBFF8

`endif

/* verilog/mem_pkg.sv */
`include "mem_defines.svh"

package mem_pkg;

    // one data word, seen as lanes of any access size
    typedef union packed {
        logic [7:0][7:0]         b;   // bytes
        logic [3:0][15:0]        h;   // halves
        logic [1:0][31:0]        w;   // words
        logic [`MEM_XLEN-1:0]    d;   // whole doubleword
    } lane_word_u;

endpackage

/* verilog/store_aligner.sv */
`include "mem_defines.svh"

module store_aligner import mem_pkg::*; (
    input  logic [2:0]           addr_lsb_i,
    input  logic [1:0]           size_i,
    input  logic [`MEM_XLEN-1:0] wdata_i,
    output lane_word_u           lane_o,
    output logic [7:0]           wmask_o
);

    // size code: 00 word, 01 byte, 10 half, 11 double
    always_comb begin
        lane_o  = '0;
        wmask_o = '0;
        case (size_i)
            2'b01: begin // byte
                lane_o.b[addr_lsb_i] = wdata_i[7:0];
                wmask_o              = 8'h01 << addr_lsb_i;
            end
            2'b10: begin // half
                lane_o.h[addr_lsb_i[2:1]] = wdata_i[15:0];
                wmask_o                   = 8'h03 << {addr_lsb_i[2:1], 1'b0};
            end
            2'b00: begin // word
                lane_o.w[addr_lsb_i[2]] = wdata_i[31:0];
                wmask_o                 = 8'h0f << {addr_lsb_i[2], 2'b00};
            end
            default: begin
                lane_o.d = wdata_i;  // double, no shifting
                wmask_o  = 8'hff;
            end
        endcase
    end

endmodule

/* verilog/dcache.sv */
`include "mem_defines.svh"

module dcache import mem_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,

    input  logic [`MEM_XLEN-1:0]   req_addr_i,
    input  logic                   req_wr_i,
    input  logic                   req_valid_i,
    input  lane_word_u             req_wdata_i,
    input  logic [7:0]             req_wmask_i,
    output logic [`MEM_XLEN-1:0]   rdata_o,
    output logic                   ready_o,
    output logic                   idle_o,

    output logic [`MEM_XLEN-1:0]   mem_addr_o,
    output logic                   mem_wr_o,
    output logic                   mem_valid_o,
    output logic [`MEM_LINE_W-1:0] mem_wdata_o,
    input  logic [`MEM_LINE_W-1:0] mem_rdata_i,
    input  logic                   mem_ready_i
);

    localparam int TAG_W = `MEM_XLEN - `MEM_IDX_BITS - `MEM_OFS_BITS;

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_LOOKUP = 2'd1;
    localparam logic [1:0] S_EVICT  = 2'd2;
    localparam logic [1:0] S_REFILL = 2'd3;

    logic [1:0]              state_q;

    logic [`MEM_LINE_W-1:0]  data_q [`MEM_LINES];
    logic [TAG_W-1:0]        tag_q  [`MEM_LINES];
    logic [`MEM_LINES-1:0]   valid_q;
    logic [`MEM_LINES-1:0]   dirty_q;

    logic [`MEM_IDX_BITS-1:0] idx;
    logic [TAG_W-1:0]         req_tag;
    logic                     word_sel;
    logic                     hit;
    logic [`MEM_LINE_W-1:0]   cur_line;
    logic [`MEM_LINE_W-1:0]   line_view;
    logic [`MEM_LINE_W-1:0]   new_line;
    logic                     refill_done;
    logic                     line_we;

    // write the masked bytes of one word into a line
    function automatic logic [`MEM_LINE_W-1:0] merge_line(
        input logic [`MEM_LINE_W-1:0] line,
        input lane_word_u             lane,
        input logic [7:0]             mask,
        input logic                   hi
    );
        logic [`MEM_LINE_W-1:0] res;
        int                     base;
        res  = line;
        base = hi ? `MEM_XLEN : 0;
        for (int i = 0; i < 8; i++) begin
            if (mask[i])
                res[base + i*8 +: 8] = lane.b[i];
        end
        return res;
    endfunction

    assign idx      = req_addr_i[`MEM_OFS_BITS +: `MEM_IDX_BITS];
    assign req_tag  = req_addr_i[`MEM_XLEN-1 -: TAG_W];
    assign word_sel = req_addr_i[`MEM_OFS_BITS-1];   // upper or lower half of the line

    assign cur_line = data_q[idx];
    assign hit      = valid_q[idx] && (tag_q[idx] == req_tag);

    assign refill_done = (state_q == S_REFILL) && mem_ready_i;

    // during refill the incoming line stands in for the array
    assign line_view = (state_q == S_REFILL) ? mem_rdata_i : cur_line;
    assign new_line  = req_wr_i ? merge_line(line_view, req_wdata_i, req_wmask_i, word_sel)
                                : line_view;

    assign line_we = ((state_q == S_LOOKUP) && hit && req_wr_i) || refill_done;

    assign rdata_o = word_sel ? line_view[`MEM_LINE_W-1 -: `MEM_XLEN]
                              : line_view[`MEM_XLEN-1:0];
    assign ready_o = ((state_q == S_LOOKUP) && hit) || refill_done;
    assign idle_o  = (state_q == S_IDLE);

    // memory port
    assign mem_valid_o = (state_q == S_EVICT) || (state_q == S_REFILL);
    assign mem_wr_o    = (state_q == S_EVICT);
    assign mem_wdata_o = cur_line;
    always_comb begin
        if (state_q == S_EVICT)
            mem_addr_o = {tag_q[idx], idx, {`MEM_OFS_BITS{1'b0}}};  // victim line
        else
            mem_addr_o = {req_tag, idx, {`MEM_OFS_BITS{1'b0}}};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (req_valid_i)
                        state_q <= S_LOOKUP;
                end
                S_LOOKUP: begin
                    if (hit) begin
                        state_q <= S_IDLE;
                        if (req_wr_i)
                            dirty_q[idx] <= 1'b1;
                    end else if (valid_q[idx] && dirty_q[idx]) begin
                        state_q <= S_EVICT;
                    end else begin
                        state_q <= S_REFILL;
                    end
                end
                S_EVICT: begin
                    if (mem_ready_i)
                        state_q <= S_REFILL;
                end
                default: begin // refill
                    if (mem_ready_i) begin
                        state_q      <= S_IDLE;
                        valid_q[idx] <= 1'b1;
                        dirty_q[idx] <= req_wr_i;  // store miss leaves the line dirty
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (line_we) begin
            data_q[idx] <= new_line;
            tag_q[idx]  <= req_tag;
        end
    end

endmodule

/* verilog/clint_timer.sv */
`include "mem_defines.svh"

module clint_timer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wen_i,
    input  logic [15:0]          offset_i,
    input  logic [`MEM_XLEN-1:0] wdata_i,
    output logic [`MEM_XLEN-1:0] rdata_o,
    output logic                 irq_o
);

    logic [`MEM_XLEN-1:0] mtime;
    logic [`MEM_XLEN-1:0] mtimecmp;

    always_ff @(posedge clk) begin
        if (rst)
            mtime <= '0;
        else
            mtime <= mtime + 1'b1;  // free running
    end

    always_ff @(posedge clk) begin
        if (rst)
            mtimecmp <= '0;
        else if (wen_i)
            mtimecmp <= wdata_i;
    end

    // only the mtime offset is decoded, all else is mtimecmp
    assign rdata_o = (offset_i == `CLINT_MTIME_OFS) ? mtime : mtimecmp;
    assign irq_o   = (mtime >= mtimecmp);

endmodule

/* verilog/load_extractor.sv */
`include "mem_defines.svh"

module load_extractor import mem_pkg::*; (
    input  logic                 is_clint_i,
    input  logic [`MEM_XLEN-1:0] cache_word_i,
    input  logic [`MEM_XLEN-1:0] clint_word_i,
    input  logic [2:0]           addr_lsb_i,
    input  logic [2:0]           mem_op_i,
    output logic [`MEM_XLEN-1:0] rdata_o
);

    lane_word_u  src;
    logic        uns;
    logic [7:0]  sel_b;
    logic [15:0] sel_h;
    logic [31:0] sel_w;

    assign src = is_clint_i ? clint_word_i : cache_word_i;
    assign uns = mem_op_i[2];

    // pick the lane at the address offset
    assign sel_b = src.b[addr_lsb_i];
    assign sel_h = src.h[addr_lsb_i[2:1]];
    assign sel_w = src.w[addr_lsb_i[2]];

    always_comb begin
        case (mem_op_i[1:0])
            2'b01:   rdata_o = {{56{sel_b[7] & ~uns}}, sel_b};
            2'b10:   rdata_o = {{48{sel_h[15] & ~uns}}, sel_h};
            2'b00:   rdata_o = {{32{sel_w[31] & ~uns}}, sel_w};
            default: rdata_o = src.d;  // ld, unsigned form too
        endcase
    end

endmodule

/* verilog/mem_stage.sv */
`include "mem_defines.svh"

module mem_stage import mem_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,

    input  logic [`MEM_XLEN-1:0]   addr_i,
    input  logic [`MEM_XLEN-1:0]   wdata_i,
    input  logic [2:0]             mem_op_i,
    input  logic                   wen_i,
    input  logic                   access_i,
    output logic [`MEM_XLEN-1:0]   rdata_o,
    output logic                   busy_o,
    output logic                   timer_irq_o,

    output logic [`MEM_XLEN-1:0]   mem_addr_o,
    output logic                   mem_wr_o,
    output logic                   mem_valid_o,
    output logic [`MEM_LINE_W-1:0] mem_wdata_o,
    input  logic [`MEM_LINE_W-1:0] mem_rdata_i,
    input  logic                   mem_ready_i
);

    lane_word_u           st_lane;
    logic [7:0]           st_mask;
    logic                 is_clint;
    logic                 cache_doing;
    logic                 cpu_req_valid;
    logic                 cpu_ready;
    logic                 cache_idle;
    logic                 clint_wen;
    logic [`MEM_XLEN-1:0] cache_word;
    logic [`MEM_XLEN-1:0] clint_word;

    assign is_clint = (addr_i[31:24] == `CLINT_HI_BYTE);

    // one cache request per access, held until the cache answers
    always_ff @(posedge clk) begin
        if (rst)
            cache_doing <= 1'b0;
        else if (cpu_ready)
            cache_doing <= 1'b0;
        else if (cpu_req_valid && cache_idle)
            cache_doing <= 1'b1;
    end

    assign cpu_req_valid = access_i && !is_clint && !cache_doing && !cpu_ready;
    assign busy_o        = access_i && !is_clint && !cpu_ready;
    assign clint_wen     = wen_i && access_i && is_clint;

    store_aligner u_store_aligner (
        .addr_lsb_i (addr_i[2:0]),
        .size_i     (mem_op_i[1:0]),
        .wdata_i    (wdata_i),
        .lane_o     (st_lane),
        .wmask_o    (st_mask)
    );

    dcache u_dcache (
        .clk         (clk),
        .rst         (rst),
        .req_addr_i  (addr_i),
        .req_wr_i    (wen_i),
        .req_valid_i (cpu_req_valid),
        .req_wdata_i (st_lane),
        .req_wmask_i (st_mask),
        .rdata_o     (cache_word),
        .ready_o     (cpu_ready),
        .idle_o      (cache_idle),
        .mem_addr_o  (mem_addr_o),
        .mem_wr_o    (mem_wr_o),
        .mem_valid_o (mem_valid_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_ready_i (mem_ready_i)
    );

    // timer takes the raw store word, not the lanes
    clint_timer u_clint_timer (
        .clk      (clk),
        .rst      (rst),
        .wen_i    (clint_wen),
        .offset_i (addr_i[15:0]),
        .wdata_i  (wdata_i),
        .rdata_o  (clint_word),
        .irq_o    (timer_irq_o)
    );

    load_extractor u_load_extractor (
        .is_clint_i   (is_clint),
        .cache_word_i (cache_word),
        .clint_word_i (clint_word),
        .addr_lsb_i   (addr_i[2:0]),
        .mem_op_i     (mem_op_i),
        .rdata_o      (rdata_o)
    );

endmodule

/* tb/mem_stage_asserts.sv */
`include "mem_defines.svh"

module mem_stage_asserts (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`MEM_XLEN-1:0] addr_i,
    input  logic                 access_i,
    input  logic                 busy_i,
    input  logic [`MEM_XLEN-1:0] mem_addr_i,
    input  logic                 mem_wr_i,
    input  logic                 mem_valid_i,
    input  logic                 mem_ready_i
);

    // memory request is a level until the ready pulse
    valid_held: assert property (@(posedge clk) disable iff (rst)
        mem_valid_i && !mem_ready_i |=> mem_valid_i)
        else $error("mem_valid_o dropped before mem_ready_i");

    addr_stable: assert property (@(posedge clk) disable iff (rst)
        mem_valid_i && !mem_ready_i |=> $stable(mem_addr_i) && $stable(mem_wr_i))
        else $error("mem_addr_o or mem_wr_o changed while waiting for mem_ready_i");

    valid_low_after_reset: assert property (@(posedge clk)
        rst |=> !mem_valid_i)
        else $error("mem_valid_o high right after reset");

    // clint answers in the same cycle and leaves the cache at rest
    clint_not_busy: assert property (@(posedge clk) disable iff (rst)
        access_i && (addr_i[31:24] == `CLINT_HI_BYTE) |-> !busy_i && !mem_valid_i)
        else $error("busy_o or mem_valid_o high on a CLINT access");

endmodule

bind mem_stage mem_stage_asserts u_asserts (
    .clk         (clk),
    .rst         (rst),
    .addr_i      (addr_i),
    .access_i    (access_i),
    .busy_i      (busy_o),
    .mem_addr_i  (mem_addr_o),
    .mem_wr_i    (mem_wr_o),
    .mem_valid_i (mem_valid_o),
    .mem_ready_i (mem_ready_i)
);

/* tb/mem_stage_checker.sv */
`include "mem_defines.svh"

module mem_stage_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`MEM_XLEN-1:0] addr_i,
    input  logic [`MEM_XLEN-1:0] wdata_i,
    input  logic [2:0]           op_i,
    input  logic                 wen_i,
    input  logic                 access_i,
    input  logic [`MEM_XLEN-1:0] rdata_i,
    input  logic                 busy_i,
    input  logic                 irq_i,
    input  logic                 check_i,
    input  int                   test_idx_i,
    output int                   errors_o,
    output int                   checks_o,
    output int                   tests_o
);

    logic [7:0]  ref_mem [1024];  // byte image of the backing memory
    logic [63:0] cycles;          // mtime prediction
    logic [63:0] cmp_copy;
    logic        is_clint;
    int          errs_before;

    function automatic logic [7:0] init_byte(input logic [9:0] a);
        return a[7:0] * 8'd29 ^ {a[9:8], a[9:8], a[9:8], a[9:8]} ^ 8'h5c;
    endfunction

    function automatic int access_bytes(input logic [1:0] size);
        case (size)
            2'b01:   return 1;
            2'b10:   return 2;
            2'b00:   return 4;
            default: return 8;
        endcase
    endfunction

    // sign or zero extension of the low nbytes
    function automatic logic [63:0] extend_value(input logic [63:0] raw, input int nbytes,
                                                 input logic uns);
        logic [63:0] mask;
        logic        sign;
        mask = (64'd1 << (8 * nbytes)) - 64'd1;
        sign = raw[8 * nbytes - 1];
        return (raw & mask) | ((sign && !uns) ? ~mask : 64'd0);
    endfunction

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks_o++;
        if (exp !== act) begin
            errors_o++;
            $display("Error %s expected %h actual %h", name, exp, act);
        end
    endtask

    assign is_clint = (addr_i[31:24] == `CLINT_HI_BYTE);

    initial begin
        errors_o    = 0;
        checks_o    = 0;
        tests_o     = 0;
        errs_before = 0;
        for (int a = 0; a < 1024; a++)
            ref_mem[a] = init_byte(a);
    end

    always @(posedge clk) begin
        if (rst) begin
            cycles   <= '0;
            cmp_copy <= '0;
        end else begin
            cycles <= cycles + 64'd1;
            if (access_i && wen_i && is_clint)
                cmp_copy <= wdata_i;  // lands at this edge
        end
    end

    always @(negedge clk) begin : watch
        logic [63:0] raw;
        int          n;
        if (!rst) begin
            compare("timer_irq_o", {63'd0, cycles >= cmp_copy}, {63'd0, irq_i});
            // an access ends when busy is low
            if (access_i && (is_clint || !busy_i)) begin
                n   = access_bytes(op_i[1:0]);
                raw = '0;
                if (!wen_i && check_i) begin
                    if (is_clint)
                        raw = ((addr_i[15:0] == `CLINT_MTIME_OFS) ? cycles : cmp_copy)
                              >> (8 * addr_i[2:0]);
                    else
                        for (int k = n - 1; k >= 0; k--)
                            raw = {raw[55:0], ref_mem[addr_i[9:0] + k]};
                    compare("rdata_o", extend_value(raw, n, op_i[2]), rdata_i);
                end
                if (wen_i && !is_clint)
                    for (int k = 0; k < n; k++)
                        ref_mem[addr_i[9:0] + k] = wdata_i[8*k +: 8];
                $display("test %0d %s addr %h: %s", test_idx_i, wen_i ? "store" : "load",
                         addr_i, (errors_o == errs_before) ? "ok" : "fail");
                errs_before = errors_o;
                tests_o++;
            end
        end
    end

endmodule

/* tb/mem_stage_tb.sv */
`include "mem_defines.svh"

module mem_stage_tb;

    typedef struct packed {
        logic [63:0] addr;
        logic [2:0]  op;
        logic        wen;
        logic [63:0] data;
        logic        chk;
    } entry_t;

    localparam logic [63:0] BASE  = 64'h8000_0000;
    localparam logic [63:0] CMP   = 64'h0200_4000;
    localparam logic [63:0] MTIME = 64'h0200_bff8;
    localparam logic [2:0]  OP_W  = 3'b000;
    localparam logic [2:0]  OP_B  = 3'b001;
    localparam logic [2:0]  OP_H  = 3'b010;
    localparam logic [2:0]  OP_D  = 3'b011;
    localparam logic [2:0]  OP_WU = 3'b100;
    localparam logic [2:0]  OP_BU = 3'b101;
    localparam logic [2:0]  OP_HU = 3'b110;

    logic                   clk;
    logic                   rst;
    logic [`MEM_XLEN-1:0]   addr_i;
    logic [`MEM_XLEN-1:0]   wdata_i;
    logic [2:0]             mem_op_i;
    logic                   wen_i;
    logic                   access_i;
    logic [`MEM_XLEN-1:0]   rdata_o;
    logic                   busy_o;
    logic                   timer_irq_o;
    logic [`MEM_XLEN-1:0]   mem_addr_o;
    logic                   mem_wr_o;
    logic                   mem_valid_o;
    logic [`MEM_LINE_W-1:0] mem_wdata_o;
    logic [`MEM_LINE_W-1:0] mem_rdata_i;
    logic                   mem_ready_i;

    logic [`MEM_LINE_W-1:0] backing [64];
    entry_t                 table_q [$];
    logic                   chk_en;
    int                     test_idx;
    int                     errors;
    int                     checks;
    int                     tests;
    integer                 seed;
    int                     delay_left;
    logic                   counting;

    mem_stage uut (
        .clk         (clk),
        .rst         (rst),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .mem_op_i    (mem_op_i),
        .wen_i       (wen_i),
        .access_i    (access_i),
        .rdata_o     (rdata_o),
        .busy_o      (busy_o),
        .timer_irq_o (timer_irq_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wr_o    (mem_wr_o),
        .mem_valid_o (mem_valid_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_ready_i (mem_ready_i)
    );

    mem_stage_checker u_checker (
        .clk        (clk),
        .rst        (rst),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .op_i       (mem_op_i),
        .wen_i      (wen_i),
        .access_i   (access_i),
        .rdata_i    (rdata_o),
        .busy_i     (busy_o),
        .irq_i      (timer_irq_o),
        .check_i    (chk_en),
        .test_idx_i (test_idx),
        .errors_o   (errors),
        .checks_o   (checks),
        .tests_o    (tests)
    );

    always #2 clk = ~clk;

    function automatic logic [7:0] init_byte(input logic [9:0] a);
        return a[7:0] * 8'd29 ^ {a[9:8], a[9:8], a[9:8], a[9:8]} ^ 8'h5c;
    endfunction

    task automatic fill_backing();
        for (int l = 0; l < 64; l++)
            for (int k = 0; k < 16; k++)
                backing[l][8*k +: 8] = init_byte(l * 16 + k);
    endtask

    task automatic add_entry(input logic [63:0] addr, input logic [2:0] op, input logic wen,
                             input logic [63:0] data, input logic chk);
        table_q.push_back({addr, op, wen, data, chk});
    endtask

    task automatic build_table();
        add_entry(CMP, OP_D, 1'b1, 64'd90, 1'b0);     // irq drops
        add_entry(CMP, OP_D, 1'b0, 64'd0, 1'b1);
        add_entry(MTIME, OP_D, 1'b0, 64'd0, 1'b1);
        add_entry(BASE, OP_D, 1'b1, 64'h0123_4567_89ab_cdef, 1'b0);
        add_entry(BASE, OP_D, 1'b0, 64'd0, 1'b1);
        add_entry(BASE + 64'h8, OP_D, 1'b0, 64'd0, 1'b1);
        for (int i = 0; i < 8; i++)
            add_entry(BASE + 64'h40 + 9 * i, OP_B, 1'b1, 64'hffff_ffff_ffff_ff90 + i, 1'b0);
        for (int i = 0; i < 8; i++)
            add_entry(BASE + 64'h40 + 8 * i, OP_D, 1'b0, 64'd0, 1'b1);
        for (int j = 0; j < 4; j++)
            add_entry(BASE + 64'h80 + 10 * j, OP_H, 1'b1, 64'h1234_5678_9abc_8000 + 64'h1111 * j,
                      1'b0);
        for (int j = 0; j < 4; j++)
            add_entry(BASE + 64'h80 + 8 * j, OP_D, 1'b0, 64'd0, 1'b1);
        add_entry(BASE + 64'ha0, OP_W, 1'b1, 64'h5555_5555_dead_beef, 1'b0);
        add_entry(BASE + 64'hac, OP_W, 1'b1, 64'h7777_7777_c0de_0001, 1'b0);
        add_entry(BASE + 64'ha0, OP_D, 1'b0, 64'd0, 1'b1);
        add_entry(BASE + 64'ha8, OP_D, 1'b0, 64'd0, 1'b1);
        add_entry(BASE + 64'h49, OP_B, 1'b0, 64'd0, 1'b1);
        add_entry(BASE + 64'h49, OP_BU, 1'b0, 64'd0, 1'b1);
        add_entry(BASE + 64'h8a, OP_H, 1'b0, 64'd0, 1'b1);
        add_entry(BASE + 64'h8a, OP_HU, 1'b0, 64'd0, 1'b1);
        add_entry(BASE + 64'hac, OP_W, 1'b0, 64'd0, 1'b1);
        add_entry(BASE + 64'hac, OP_WU, 1'b0, 64'd0, 1'b1);
        // same index as BASE, so dirty lines get evicted
        add_entry(BASE + 64'h100, OP_D, 1'b1, 64'hfeed_face_cafe_beef, 1'b0);
        add_entry(BASE, OP_D, 1'b0, 64'd0, 1'b1);
        add_entry(BASE + 64'h100, OP_D, 1'b0, 64'd0, 1'b1);
        add_entry(BASE + 64'h200, OP_D, 1'b0, 64'd0, 1'b1);  // untouched lines
        add_entry(BASE + 64'h2f8, OP_D, 1'b0, 64'd0, 1'b1);
        add_entry(BASE + 64'h3a0, OP_D, 1'b0, 64'd0, 1'b1);
        add_entry(BASE + 64'h3c4, OP_W, 1'b0, 64'd0, 1'b1);
        add_entry(CMP, OP_D, 1'b0, 64'd0, 1'b1);
        add_entry(MTIME, OP_D, 1'b0, 64'd0, 1'b1);
        add_entry(CMP + 64'h4, OP_WU, 1'b0, 64'd0, 1'b1);
    endtask

    // memory port, random 1 to 4 cycle response
    always @(posedge clk) begin
        if (rst) begin
            mem_ready_i <= 1'b0;
            counting = 1'b0;
        end else if (mem_ready_i) begin
            if (mem_wr_o)
                backing[mem_addr_o[9:4]] = mem_wdata_o;
            mem_ready_i <= 1'b0;
            counting = 1'b0;
        end else if (mem_valid_o) begin
            if (!counting) begin
                counting   = 1'b1;
                delay_left = ($unsigned($random(seed)) % 4) + 1;
            end
            delay_left = delay_left - 1;
            if (delay_left == 0) begin
                mem_ready_i <= 1'b1;
                mem_rdata_i <= backing[mem_addr_o[9:4]];
            end
        end
    end

    initial begin
        seed        = 32'h22ef_9cfb;
        clk         = 1'b0;
        rst         = 1'b1;
        addr_i      = '0;
        wdata_i     = '0;
        mem_op_i    = '0;
        wen_i       = 1'b0;
        access_i    = 1'b0;
        mem_rdata_i = '0;
        mem_ready_i = 1'b0;
        chk_en      = 1'b0;
        test_idx    = 0;
        counting    = 1'b0;
        delay_left  = 0;
        build_table();
        fill_backing();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        foreach (table_q[i]) begin
            @(posedge clk);
            addr_i   <= table_q[i].addr;
            mem_op_i <= table_q[i].op;
            wen_i    <= table_q[i].wen;
            wdata_i  <= table_q[i].data;
            chk_en   <= table_q[i].chk;
            access_i <= 1'b1;
            test_idx <= i;
            if (table_q[i].addr[31:24] != `CLINT_HI_BYTE) begin
                do @(negedge clk); while (busy_o);
            end
        end
        @(posedge clk);
        access_i <= 1'b0;
        wen_i    <= 1'b0;
        repeat (2) @(posedge clk);
        if (tests != table_q.size())
            $display("only %0d of %0d tests completed", tests, table_q.size());
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && tests == table_q.size()) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #1;
        repeat (table_q.size() * 40) @(posedge clk);
        $display("timeout, the DUT stopped finishing its accesses");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* sources.f */
+incdir+verilog
verilog/mem_pkg.sv
verilog/store_aligner.sv
verilog/dcache.sv
verilog/clint_timer.sv
verilog/load_extractor.sv
verilog/mem_stage.sv
tb/mem_stage_asserts.sv
tb/mem_stage_checker.sv
tb/mem_stage_tb.sv
